//--- rtl/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// CPU bus widths
`define BUS_ADDR_W      16
`define BUS_DATA_W      8
`define BANK_PAGE_W     6

// I/O port map (bank n sits at IO_BANK0 + n)
`define IO_BANK0        8'hF0
`define IO_SYSCTRL      8'hFB
`define IO_CASSETTE     8'hFC
`define IO_CPM_VSYNC    8'hFD   // Read vblank, write CP/M remap
`define IO_PRINTER      8'hFE
`define IO_KEYB         8'hFF

// Bank register reset values {ro, overlay, page}
`define BANK0_RESET     8'hC0   // Read-only, overlay, page 0
`define BANK1_RESET     8'h21   // Page 33
`define BANK2_RESET     8'h22   // Page 34
`define BANK3_RESET     8'h13   // Page 19

`define ROM_LAST_PAGE   6'd15
`define RAM_FIRST_PAGE  6'd32
`define SYSRAM_BLOCK    3'd7    // A[13:11] of $3800-$3FFF
`define WR_SYNC_DEPTH   3
`endif

//--- rtl/bus_pkg.sv
`include "bus_config.svh"

package bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // Z80 expansion bus types
    //////////////////////////////////////////////////////////////////////

    // Full CPU address, A15..A0
    typedef logic [`BUS_ADDR_W-1:0] addr_t;

    // One byte on the data bus
    typedef logic [`BUS_DATA_W-1:0] data_t;

    // Bank page number
    // Pages 0-15 are flash, 32-63 are RAM, the rest is unmapped here
    typedef logic [`BANK_PAGE_W-1:0] page_t;

    // A bus address is split in a 2-bit bank index and a 14-bit offset
    // inside the 16KB window; the bank index picks one of F0..F3.
    // The offset goes straight to the memory chips, the page
    // from the bank register supplies the upper address lines.
    // The I/O space uses only A7..A0 as port number, A15..A8 carry
    // the keyboard row select during an IN from port FF.

endpackage

//--- rtl/regs_pkg.sv
package regs_pkg;

    import bus_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // I/O register file types
    //////////////////////////////////////////////////////////////////////

    // Bank register layout, as read back from F0..F3
    typedef struct packed {
        logic  ro;        // Block writes to this bank
        logic  overlay;   // System RAM at $3800-$3FFF
        page_t page;
    } bank_reg_t;

    // Index matches A[15:14]
    typedef bank_reg_t [3:0] bank_array_t;

    // Decoded I/O port selects, at most one set
    typedef struct packed {
        logic bank0;
        logic bank1;
        logic bank2;
        logic bank3;
        logic sysctrl;    // FB
        logic cassette;   // FC
        logic cpm_vsync;  // FD
        logic printer;    // FE
        logic keyb;       // FF
    } io_sel_t;

endpackage

//--- rtl/cpu_bus_if.sv
`timescale 1ns/10ps

interface cpu_bus_if;

    import bus_pkg::*;

    addr_t addr;
    data_t d_in;
    logic  rd_n;
    logic  wr_n;
    logic  mreq_n;
    logic  iorq_n;

    // Write strobe and data capture
    modport sync_mp   (input d_in, input wr_n);

    // I/O port decode
    modport regs_mp   (input addr, input iorq_n);

    // Memory chip selects
    modport decode_mp (input addr, input mreq_n, input wr_n);

    // I/O readback
    modport read_mp   (input addr, input rd_n);

endinterface

//--- rtl/bus_strobe_sync.sv
`timescale 1ns/10ps

`include "bus_config.svh"

module bus_strobe_sync (
    input  logic           sysclk,
    input  logic           reset,
    cpu_bus_if.sync_mp     bus,
    output logic           wr_valid,
    output bus_pkg::data_t wr_data
);

    // Extra top bit keeps the previous synchronised level
    logic [`WR_SYNC_DEPTH:0] wr_n_sync;
    logic                    wr_fall;

    //////////////////////////////////////////////////////////////////////
    // Strobe synchroniser
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_n_sync <= '1;                            // Bus idle
        end else begin
            wr_n_sync <= {wr_n_sync[`WR_SYNC_DEPTH-1:0], bus.wr_n};
        end
    end

    // High to low on the last stage
    assign wr_fall = wr_n_sync[`WR_SYNC_DEPTH] && !wr_n_sync[`WR_SYNC_DEPTH-1];

    // One cycle per CPU write
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= wr_fall;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write data capture
    //////////////////////////////////////////////////////////////////////

    // Data is stable long before the event fires
    always_ff @(posedge sysclk) begin
        if (!bus.wr_n) wr_data <= bus.d_in;
    end

endmodule

//--- rtl/io_regfile.sv
`timescale 1ns/10ps

`include "bus_config.svh"

module io_regfile (
    input  logic                  sysclk,
    input  logic                  reset,
    cpu_bus_if.regs_mp            bus,
    input  logic                  wr_valid,
    input  bus_pkg::data_t        wr_data,
    output regs_pkg::io_sel_t     io_sel,
    output regs_pkg::bank_array_t banks,
    output logic                  dis_regs,
    output logic                  cpm_remap,
    output logic                  cassette_out,
    output logic                  printer_out
);

    import regs_pkg::*;

    logic [7:0] port;

    assign port = bus.addr[7:0];                        // Z80 I/O uses A7..A0

    //////////////////////////////////////////////////////////////////////
    // Port decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        io_sel = '0;
        if (!bus.iorq_n) begin
            // Bank registers vanish while disabled
            io_sel.bank0     = !dis_regs && port == `IO_BANK0;
            io_sel.bank1     = !dis_regs && port == `IO_BANK0 + 8'd1;
            io_sel.bank2     = !dis_regs && port == `IO_BANK0 + 8'd2;
            io_sel.bank3     = !dis_regs && port == `IO_BANK0 + 8'd3;
            io_sel.sysctrl   = port == `IO_SYSCTRL;      // Always reachable
            io_sel.cassette  = port == `IO_CASSETTE;
            io_sel.cpm_vsync = port == `IO_CPM_VSYNC;
            io_sel.printer   = port == `IO_PRINTER;
            io_sel.keyb      = port == `IO_KEYB;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register state
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            banks[0]     <= bank_reg_t'(`BANK0_RESET);  // Boot ROM with sysram
            banks[1]     <= bank_reg_t'(`BANK1_RESET);
            banks[2]     <= bank_reg_t'(`BANK2_RESET);
            banks[3]     <= bank_reg_t'(`BANK3_RESET);
            dis_regs     <= 1'b0;
            cpm_remap    <= 1'b0;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (wr_valid) begin
            if (io_sel.bank0) banks[0] <= bank_reg_t'(wr_data);
            if (io_sel.bank1) banks[1] <= bank_reg_t'(wr_data);
            if (io_sel.bank2) banks[2] <= bank_reg_t'(wr_data);
            if (io_sel.bank3) banks[3] <= bank_reg_t'(wr_data);

            // One-bit latches take D0
            if (io_sel.sysctrl)   dis_regs     <= wr_data[0];
            if (io_sel.cassette)  cassette_out <= wr_data[0];
            if (io_sel.cpm_vsync) cpm_remap    <= wr_data[0];
            if (io_sel.printer)   printer_out  <= wr_data[0];
        end
    end

endmodule

//--- rtl/bank_decoder.sv
`timescale 1ns/10ps

`include "bus_config.svh"

module bank_decoder (
    cpu_bus_if.decode_mp          bus,
    input  regs_pkg::bank_array_t banks,
    output logic                  rom_ce_n,
    output logic                  ram_ce_n,
    output logic                  ram_rom_we_n,
    output logic [4:0]            ba
);

    import regs_pkg::*;

    bank_reg_t bank;
    logic      sel_sysram;
    logic      allow_mem;
    logic      sel_rom;
    logic      sel_ram;

    //////////////////////////////////////////////////////////////////////
    // Bank selection
    //////////////////////////////////////////////////////////////////////

    // 16KB windows
    assign bank = banks[bus.addr[15:14]];

    // $3800-$3FFF goes to RAM page 0 when overlaid
    assign sel_sysram = !bus.mreq_n && bank.overlay &&
                        bus.addr[13:11] == `SYSRAM_BLOCK;

    //////////////////////////////////////////////////////////////////////
    // Chip enables
    //////////////////////////////////////////////////////////////////////

    // Write to a read-only bank selects nothing
    assign allow_mem = !bus.mreq_n && !sel_sysram && (bus.wr_n || !bank.ro);

    assign sel_rom = allow_mem && bank.page <= `ROM_LAST_PAGE;
    assign sel_ram = (allow_mem && bank.page >= `RAM_FIRST_PAGE) || sel_sysram;

    assign rom_ce_n = !sel_rom;
    assign ram_ce_n = !sel_ram;

    // Protection already folded into the selects
    assign ram_rom_we_n = !(!bus.wr_n && (sel_rom || sel_ram));

    // Sysram lives at the bottom of the RAM chip
    assign ba = sel_sysram ? 5'd0 : bank.page[4:0];

endmodule

//--- rtl/io_read_mux.sv
`timescale 1ns/10ps

module io_read_mux (
    cpu_bus_if.read_mp            bus,
    input  regs_pkg::io_sel_t     io_sel,
    input  regs_pkg::bank_array_t banks,
    input  logic                  dis_regs,
    input  logic [63:0]           keys,
    input  logic                  cassette_in,
    input  logic                  printer_in,
    input  logic                  vblank,
    output bus_pkg::data_t        d_out,
    output logic                  d_oe
);

    import bus_pkg::*;

    data_t kb_byte;
    data_t rd_byte;

    //////////////////////////////////////////////////////////////////////
    // Keyboard matrix
    //////////////////////////////////////////////////////////////////////

    // Row i is scanned while A[8+i] is low, keys are active low
    always_comb begin
        kb_byte = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!bus.addr[8+row]) kb_byte &= keys[8*row +: 8];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_byte = '0;
        if (io_sel.bank0)     rd_byte = banks[0];
        if (io_sel.bank1)     rd_byte = banks[1];
        if (io_sel.bank2)     rd_byte = banks[2];
        if (io_sel.bank3)     rd_byte = banks[3];
        if (io_sel.sysctrl)   rd_byte = {7'b0, dis_regs};
        if (io_sel.cassette)  rd_byte = {7'b0, cassette_in};
        if (io_sel.cpm_vsync) rd_byte = {7'b0, !vblank};   // High outside blanking
        if (io_sel.printer)   rd_byte = {7'b0, printer_in};
        if (io_sel.keyb)      rd_byte = kb_byte;
    end

    // Drive the bus only for our own ports
    assign d_oe  = !bus.rd_n && (|io_sel);
    assign d_out = d_oe ? rd_byte : '0;

endmodule

//--- rtl/bus_glue_top.sv
`timescale 1ns/10ps

module bus_glue_top (
    input  logic           sysclk,
    input  logic           reset,

    // Z80 bus
    input  bus_pkg::addr_t addr,
    input  bus_pkg::data_t d_in,
    input  logic           rd_n,
    input  logic           wr_n,
    input  logic           mreq_n,
    input  logic           iorq_n,
    output bus_pkg::data_t d_out,
    output logic           d_oe,

    // Memory
    output logic           rom_ce_n,
    output logic           ram_ce_n,
    output logic           ram_rom_we_n,
    output logic [4:0]     ba,

    // Peripherals
    input  logic [63:0]    keys,
    input  logic           cassette_in,
    input  logic           printer_in,
    input  logic           vblank,
    output logic           cassette_out,
    output logic           printer_out,
    output logic           cpm_remap
);

    import bus_pkg::*;
    import regs_pkg::*;

    logic        wr_valid;
    data_t       wr_data;
    io_sel_t     io_sel;
    bank_array_t banks;
    logic        dis_regs;

    //////////////////////////////////////////////////////////////////////
    // Bus bundle
    //////////////////////////////////////////////////////////////////////
    cpu_bus_if bus ();

    assign bus.addr   = addr;
    assign bus.d_in   = d_in;
    assign bus.rd_n   = rd_n;
    assign bus.wr_n   = wr_n;
    assign bus.mreq_n = mreq_n;
    assign bus.iorq_n = iorq_n;

    //////////////////////////////////////////////////////////////////////
    // Submodules
    //////////////////////////////////////////////////////////////////////
    bus_strobe_sync u_sync (
        .sysclk(sysclk), .reset(reset), .bus(bus.sync_mp),
        .wr_valid(wr_valid), .wr_data(wr_data));

    io_regfile u_regs (
        .sysclk(sysclk), .reset(reset), .bus(bus.regs_mp),
        .wr_valid(wr_valid), .wr_data(wr_data),
        .io_sel(io_sel), .banks(banks), .dis_regs(dis_regs), .cpm_remap(cpm_remap),
        .cassette_out(cassette_out), .printer_out(printer_out));

    bank_decoder u_decode (
        .bus(bus.decode_mp), .banks(banks),
        .rom_ce_n(rom_ce_n), .ram_ce_n(ram_ce_n), .ram_rom_we_n(ram_rom_we_n), .ba(ba));

    io_read_mux u_read (
        .bus(bus.read_mp), .io_sel(io_sel), .banks(banks), .dis_regs(dis_regs),
        .keys(keys), .cassette_in(cassette_in), .printer_in(printer_in), .vblank(vblank),
        .d_out(d_out), .d_oe(d_oe));

endmodule

//--- dv/bus_glue_assert.sv
`timescale 1ns/10ps

module bus_glue_assert (
    input logic sysclk,
    input logic reset,
    input logic mreq_n,
    input logic rd_n,
    input logic rom_ce_n,
    input logic ram_ce_n,
    input logic ram_rom_we_n,
    input logic d_oe
);

    int fail_count = 0;                     // Read by the testbench at the end

    // ROM and RAM never share the bus
    chip_exclusive: assert property (@(posedge sysclk) disable iff (reset)
        !(!rom_ce_n && !ram_ce_n))
        else begin
            fail_count++;
            $error("rom_ce_n and ram_ce_n both low");
        end

    // Memory enables only during a memory cycle
    enables_need_mreq: assert property (@(posedge sysclk) disable iff (reset)
        mreq_n |-> (rom_ce_n && ram_ce_n && ram_rom_we_n))
        else begin
            fail_count++;
            $error("memory enable low while mreq_n high");
        end

    oe_needs_read: assert property (@(posedge sysclk) disable iff (reset)
        rd_n |-> !d_oe)
        else begin
            fail_count++;
            $error("d_oe high while rd_n high");
        end

endmodule

bind bus_glue_top bus_glue_assert u_assert (
    .sysclk(sysclk), .reset(reset), .mreq_n(mreq_n), .rd_n(rd_n),
    .rom_ce_n(rom_ce_n), .ram_ce_n(ram_ce_n), .ram_rom_we_n(ram_rom_we_n), .d_oe(d_oe));

//--- dv/tb_bus_glue.sv
`timescale 1ns/10ps

`include "bus_config.svh"

module tb_bus_glue;

    import bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;   // ~120 bus cycles plus margin

    logic        sysclk;
    logic        reset;
    addr_t       addr;
    data_t       d_in;
    logic        rd_n;
    logic        wr_n;
    logic        mreq_n;
    logic        iorq_n;
    logic [63:0] keys;
    logic        cassette_in;
    logic        printer_in;
    logic        vblank;
    data_t       d_out;
    logic        d_oe;
    logic        rom_ce_n;
    logic        ram_ce_n;
    logic        ram_rom_we_n;
    logic [4:0]  ba;
    logic        cassette_out;
    logic        printer_out;
    logic        cpm_remap;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state   = 32'd18;

    bus_glue_top DUT (.*);

    always #2 sysclk = ~sysclk;             // 4 ns period

    always @(posedge sysclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a bus task never completed", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // A key bit reads low if any row with a low address bit has it low
    function automatic data_t keyboard_expect(input logic [63:0] k, input data_t hi);
        data_t r;
        for (int b = 0; b < 8; b++) begin
            r[b] = 1'b1;
            for (int i = 0; i < 8; i++) begin
                r[b] = r[b] & (hi[i] | k[8*i + b]);
            end
        end
        return r;
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge sysclk);
        #1;                                 // Drive just after the edge
    endtask

    task automatic compare_value(input string name, input logic [7:0] actual,
                                 input logic [7:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////////////////////////////////
    task automatic io_write(input data_t port, input data_t data);
        addr   = {8'h00, port};
        d_in   = data;
        iorq_n = 1'b0;
        wr_n   = 1'b0;
        step(6);
        wr_n   = 1'b1;
        iorq_n = 1'b1;
        step(2);                            // Idle gap
    endtask

    task automatic io_read_check(input data_t hi, input data_t port,
                                 input logic exp_oe, input data_t exp_data);
        addr   = {hi, port};
        iorq_n = 1'b0;
        rd_n   = 1'b0;
        step(2);
        compare_value("d_oe", d_oe, exp_oe);
        compare_value("d_out", d_out, exp_oe ? exp_data : 8'h00);
        rd_n   = 1'b1;
        iorq_n = 1'b1;
        step(1);
    endtask

    task automatic mem_cycle_check(input addr_t a, input logic is_write, input logic exp_rom,
                                   input logic exp_ram, input logic exp_we,
                                   input logic [4:0] exp_ba);
        addr   = a;
        mreq_n = 1'b0;
        if (is_write) wr_n = 1'b0;
        else rd_n = 1'b0;
        step(2);
        compare_value("rom_ce_n", rom_ce_n, exp_rom);
        compare_value("ram_ce_n", ram_ce_n, exp_ram);
        compare_value("ram_rom_we_n", ram_rom_we_n, exp_we);
        compare_value("ba", ba, exp_ba);
        mreq_n = 1'b1;
        wr_n   = 1'b1;
        rd_n   = 1'b1;
        step(1);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////
    task automatic check_reset_state();
        compare_value("d_oe", d_oe, 1'b0);              // Idle bus
        compare_value("cassette_out", cassette_out, 1'b0);
        compare_value("printer_out", printer_out, 1'b0);
        compare_value("cpm_remap", cpm_remap, 1'b0);
        io_read_check(8'h00, `IO_BANK0,        1'b1, 8'hC0);   // RO, overlay, page 0
        io_read_check(8'h00, `IO_BANK0 + 8'd1, 1'b1, 8'd33);
        io_read_check(8'h00, `IO_BANK0 + 8'd2, 1'b1, 8'd34);
        io_read_check(8'h00, `IO_BANK0 + 8'd3, 1'b1, 8'd19);
        io_read_check(8'h00, `IO_SYSCTRL,      1'b1, 8'h00);
    endtask

    task automatic map_banks();
        io_write(`IO_BANK0 + 8'd1, 8'd5);
        mem_cycle_check(16'h4000, 1'b0, 1'b0, 1'b1, 1'b1, 5'd5);
        io_write(`IO_BANK0 + 8'd2, 8'd40);
        mem_cycle_check(16'h8000, 1'b1, 1'b1, 1'b0, 1'b0, 5'd8);  // Page 40 is RAM 8
        io_write(`IO_BANK0 + 8'd2, 8'd17);
        mem_cycle_check(16'h8000, 1'b0, 1'b1, 1'b1, 1'b1, 5'd17); // Unmapped hole
    endtask

    task automatic protect_writes();
        io_write(`IO_BANK0 + 8'd3, 8'h80 | 8'd36);
        mem_cycle_check(16'hC000, 1'b1, 1'b1, 1'b1, 1'b1, 5'd4);
        mem_cycle_check(16'hC000, 1'b0, 1'b1, 1'b0, 1'b1, 5'd4);
    endtask

    task automatic overlay_sysram();
        mem_cycle_check(16'h3900, 1'b1, 1'b1, 1'b0, 1'b0, 5'd0);  // Writable despite RO
        mem_cycle_check(16'h1000, 1'b0, 1'b0, 1'b1, 1'b1, 5'd0);
    endtask

    task automatic read_status_and_keys();
        data_t hi_pat [6];
        hi_pat = '{8'hFF, 8'hFE, 8'h7F, 8'h00, 8'hA5, 8'h3C};
        cassette_in = 1'b1;
        io_read_check(8'h00, `IO_CASSETTE, 1'b1, 8'h01);
        cassette_in = 1'b0;
        io_read_check(8'h00, `IO_CASSETTE, 1'b1, 8'h00);
        vblank = 1'b1;
        io_read_check(8'h00, `IO_CPM_VSYNC, 1'b1, 8'h00);
        vblank = 1'b0;
        io_read_check(8'h00, `IO_CPM_VSYNC, 1'b1, 8'h01);
        printer_in = 1'b1;
        io_read_check(8'h00, `IO_PRINTER, 1'b1, 8'h01);
        printer_in = 1'b0;
        io_read_check(8'h00, `IO_PRINTER, 1'b1, 8'h00);
        io_write(`IO_CASSETTE, 8'h01);
        compare_value("cassette_out", cassette_out, 1'b1);
        io_write(`IO_PRINTER, 8'h01);
        compare_value("printer_out", printer_out, 1'b1);
        io_write(`IO_CPM_VSYNC, 8'h01);
        compare_value("cpm_remap", cpm_remap, 1'b1);

        // Random active-low key matrices
        for (int k = 0; k < 4; k++) begin
            rng_state   = xorshift32(rng_state);
            keys[63:32] = rng_state;
            rng_state   = xorshift32(rng_state);
            keys[31:0]  = rng_state;
            foreach (hi_pat[p]) begin
                io_read_check(hi_pat[p], `IO_KEYB, 1'b1, keyboard_expect(keys, hi_pat[p]));
            end
        end
    endtask

    task automatic disable_bank_ports();
        io_write(`IO_SYSCTRL, 8'h01);
        io_read_check(8'h00, `IO_BANK0 + 8'd1, 1'b0, 8'h00);      // Bank ports hidden
        io_write(`IO_BANK0 + 8'd1, 8'h3F);
        mem_cycle_check(16'h4000, 1'b0, 1'b0, 1'b1, 1'b1, 5'd5);  // Still page 5
        io_read_check(8'h00, `IO_SYSCTRL, 1'b1, 8'h01);
        io_write(`IO_SYSCTRL, 8'h00);
        io_read_check(8'h00, `IO_BANK0 + 8'd1, 1'b1, 8'd5);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        sysclk      = 1'b0;
        reset       = 1'b1;
        addr        = '0;
        d_in        = '0;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        keys        = '1;                   // No key pressed
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        vblank      = 1'b0;
        step(4);
        reset = 1'b0;
        step(2);

        check_reset_state();
        map_banks();
        protect_writes();
        overlay_sysram();
        read_status_and_keys();
        disable_bank_ports();

        error_count += DUT.u_assert.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, DUT.u_assert.fail_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/bus_pkg.sv
rtl/regs_pkg.sv
rtl/cpu_bus_if.sv
rtl/bus_strobe_sync.sv
rtl/io_regfile.sv
rtl/bank_decoder.sv
rtl/io_read_mux.sv
rtl/bus_glue_top.sv
dv/bus_glue_assert.sv
dv/tb_bus_glue.sv

//--- Bender.yml
package:
  name: bus_glue

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/bus_pkg.sv
      - rtl/regs_pkg.sv
      - rtl/cpu_bus_if.sv
      - rtl/bus_strobe_sync.sv
      - rtl/io_regfile.sv
      - rtl/bank_decoder.sv
      - rtl/io_read_mux.sv
      - rtl/bus_glue_top.sv
  - target: test
    files:
      - dv/bus_glue_assert.sv
      - dv/tb_bus_glue.sv
